// File: Bender.yml
package:
  name: engine_read_write

sources:
  - rw_engine_pkg.sv
  - response_router.sv
  - config_loader.sv
  - engine_control_fsm.sv
  - packet_counter.sv
  - request_generator.sv
  - engine_read_write.sv
  - target: simulation
    files:
      - tb_engine_read_write.sv

// File: compile.f
rw_engine_pkg.sv
response_router.sv
config_loader.sv
engine_control_fsm.sv
packet_counter.sv
request_generator.sv
engine_read_write.sv
tb_engine_read_write.sv

// File: config_loader.sv
// Configuration register bank for base, stride, count and opcode with arrival mask
`timescale 1ns/10ps
`default_nettype none

module config_loader import rw_engine_pkg::*; (
    input  wire logic               ap_clk,
    input  wire logic               areset_read_write_engine,
    input  wire logic               cfg_valid,
    input  wire logic [index_w-1:0] cfg_index,
    input  wire logic [data_w-1:0]  cfg_data,
    output logic [addr_w-1:0]       base_addr,
    output logic [addr_w-1:0]       stride,
    output logic [count_w-1:0]      packet_count,
    output engine_op_t              opcode,
    output logic                    cfg_ready
);

    // One bit per configuration word seen since reset
    logic [cfg_words-1:0] cfg_mask;

    // ------------------------------------------------------------
    // Arrival mask
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            cfg_mask <= '0;
        end else if (cfg_valid) begin
            case (cfg_index)
                cfg_base:   cfg_mask[0] <= 1'b1;
                cfg_stride: cfg_mask[1] <= 1'b1;
                cfg_count:  cfg_mask[2] <= 1'b1;
                cfg_opcode: cfg_mask[3] <= 1'b1;
                default:    cfg_mask    <= cfg_mask;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Word registers
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (cfg_valid) begin
            case (cfg_index)
                cfg_base:   base_addr    <= cfg_data[addr_w-1:0];
                cfg_stride: stride       <= cfg_data[addr_w-1:0];
                cfg_count:  packet_count <= cfg_data[count_w-1:0];
                // Only bit 0 encodes the operation
                cfg_opcode: opcode       <= engine_op_t'(cfg_data[0]);
                default:    ;
            endcase
        end
    end

    // High in the same cycle the last word lands
    assign cfg_ready = &cfg_mask;

    // Opcode word from memory must be a plain 0 or 1 encoding
    a_opcode_legal : assert property (@(posedge ap_clk) disable iff (areset_read_write_engine)
        (cfg_valid && cfg_index == cfg_opcode) |-> (cfg_data < data_w'(2)));

endmodule : config_loader

`default_nettype wire

// File: engine_control_fsm.sv
// Engine sequencing FSM for configure, run and done with packet gating
`timescale 1ns/10ps
`default_nettype none

module engine_control_fsm import rw_engine_pkg::*; (
    input  wire logic ap_clk,
    input  wire logic areset_read_write_engine,
    input  wire logic cfg_ready,
    input  wire logic count_reached,
    input  wire logic reads_idle,
    output logic      accept_en,
    output logic      done_out
);

    engine_state_t state_q;
    engine_state_t state_next;

    // ------------------------------------------------------------
    // State register
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_next;
        end
    end

    // ------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------
    always_comb begin
        state_next = state_q;
        unique case (state_q)
            // Leave idle on the first cycle out of reset
            st_idle: state_next = st_configure;
            // Wait for all four words
            st_configure: begin
                if (cfg_ready) begin
                    state_next = st_run;
                end
            end
            // Finish once every packet issued and no read left in flight
            st_run: begin
                if (count_reached && reads_idle) begin
                    state_next = st_done;
                end
            end
            // Terminal until reset
            st_done: state_next = st_done;
            default: state_next = st_idle;
        endcase
    end

    // Packet path open only while running below the count
    assign accept_en = (state_q == st_run) && !count_reached;
    assign done_out  = (state_q == st_done);

    // Completion never reported with reads still out at the memory
    a_done_reads_idle : assert property (@(posedge ap_clk) disable iff (areset_read_write_engine)
        done_out |-> reads_idle);

endmodule : engine_control_fsm

`default_nettype wire

// File: engine_read_write.sv
// Read/write engine top level connecting router, loader, FSM, counter and generator
`timescale 1ns/10ps
`default_nettype none

module engine_read_write import rw_engine_pkg::*; (
    input  wire logic               ap_clk,
    input  wire logic               areset_read_write_engine,
    input  wire logic               engine_in_valid,
    input  wire logic [index_w-1:0] engine_in_index,
    input  wire logic [data_w-1:0]  engine_in_data,
    input  wire logic               mem_resp_valid,
    input  wire resp_kind_t         mem_resp_kind,
    input  wire logic [index_w-1:0] mem_resp_tag,
    input  wire logic [data_w-1:0]  mem_resp_data,
    output logic                    mem_req_valid,
    output mem_cmd_t                mem_req_cmd,
    output logic [addr_w-1:0]       mem_req_addr,
    output logic [index_w-1:0]      mem_req_tag,
    output logic [data_w-1:0]       mem_req_data,
    output logic                    engine_out_valid,
    output logic [index_w-1:0]      engine_out_index,
    output logic [data_w-1:0]       engine_out_data,
    output logic                    done_out
);

    // ------------------------------------------------------------
    // Internal nets
    // ------------------------------------------------------------
    // Router outputs
    logic               cfg_valid;
    logic [index_w-1:0] cfg_index;
    logic [data_w-1:0]  cfg_data;
    logic               rd_valid;
    logic [index_w-1:0] rd_tag;
    logic [data_w-1:0]  rd_data;

    // Configuration
    logic [addr_w-1:0]  base_addr;
    logic [addr_w-1:0]  stride;
    logic [count_w-1:0] packet_count;
    engine_op_t         opcode;
    logic               cfg_ready;

    // Control and counting
    logic               accept_en;
    logic               read_issue;
    logic               write_issue;
    logic               count_reached;
    logic               reads_idle;

    response_router u_router (
        .ap_clk, .areset_read_write_engine,
        .mem_resp_valid, .mem_resp_kind, .mem_resp_tag, .mem_resp_data,
        .cfg_valid, .cfg_index, .cfg_data, .rd_valid, .rd_tag, .rd_data
    );

    config_loader u_loader (
        .ap_clk, .areset_read_write_engine, .cfg_valid, .cfg_index, .cfg_data,
        .base_addr, .stride, .packet_count, .opcode, .cfg_ready
    );

    engine_control_fsm u_fsm (
        .ap_clk, .areset_read_write_engine, .cfg_ready, .count_reached,
        .reads_idle, .accept_en, .done_out
    );

    // Read data strobe doubles as the return count
    packet_counter u_counter (
        .ap_clk, .areset_read_write_engine, .packet_count, .read_issue,
        .write_issue, .read_return(rd_valid), .count_reached, .reads_idle
    );

    request_generator u_generator (
        .ap_clk, .areset_read_write_engine, .accept_en, .base_addr, .stride, .opcode,
        .engine_in_valid, .engine_in_index, .engine_in_data, .rd_valid, .rd_tag, .rd_data,
        .mem_req_valid, .mem_req_cmd, .mem_req_addr, .mem_req_tag, .mem_req_data,
        .read_issue, .write_issue, .engine_out_valid, .engine_out_index, .engine_out_data
    );

endmodule : engine_read_write

`default_nettype wire

// File: packet_counter.sv
// Issued packet counter and outstanding read tracker
`timescale 1ns/10ps
`default_nettype none

module packet_counter import rw_engine_pkg::*; (
    input  wire logic               ap_clk,
    input  wire logic               areset_read_write_engine,
    input  wire logic [count_w-1:0] packet_count,
    input  wire logic               read_issue,
    input  wire logic               write_issue,
    input  wire logic               read_return,
    output logic                    count_reached,
    output logic                    reads_idle
);

    logic [count_w-1:0] issued_cnt;
    logic [count_w-1:0] reads_out_cnt;

    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            issued_cnt    <= '0;
            reads_out_cnt <= '0;
        end else begin
            // Every accepted packet counts, read or write
            if (read_issue || write_issue) begin
                issued_cnt <= issued_cnt + count_w'(1);
            end
            // Issue and return in one cycle cancel out
            case ({read_issue, read_return})
                2'b10:   reads_out_cnt <= reads_out_cnt + count_w'(1);
                2'b01:   reads_out_cnt <= reads_out_cnt - count_w'(1);
                default: reads_out_cnt <= reads_out_cnt;
            endcase
        end
    end

    // A zero count is reached right away
    assign count_reached = (issued_cnt >= packet_count);
    assign reads_idle    = (reads_out_cnt == '0);

    // Memory only returns data for reads this engine issued
    a_no_orphan_return : assert property (@(posedge ap_clk) disable iff (areset_read_write_engine)
        read_return |-> (reads_out_cnt != '0));

endmodule : packet_counter

`default_nettype wire

// File: request_generator.sv
// Memory request builder for engine packets and engine output for read data
`timescale 1ns/10ps
`default_nettype none

module request_generator import rw_engine_pkg::*; (
    input  wire logic               ap_clk,
    input  wire logic               areset_read_write_engine,
    input  wire logic               accept_en,
    input  wire logic [addr_w-1:0]  base_addr,
    input  wire logic [addr_w-1:0]  stride,
    input  wire engine_op_t         opcode,
    input  wire logic               engine_in_valid,
    input  wire logic [index_w-1:0] engine_in_index,
    input  wire logic [data_w-1:0]  engine_in_data,
    input  wire logic               rd_valid,
    input  wire logic [index_w-1:0] rd_tag,
    input  wire logic [data_w-1:0]  rd_data,
    output logic                    mem_req_valid,
    output mem_cmd_t                mem_req_cmd,
    output logic [addr_w-1:0]       mem_req_addr,
    output logic [index_w-1:0]      mem_req_tag,
    output logic [data_w-1:0]       mem_req_data,
    output logic                    read_issue,
    output logic                    write_issue,
    output logic                    engine_out_valid,
    output logic [index_w-1:0]      engine_out_index,
    output logic [data_w-1:0]       engine_out_data
);

    logic               in_valid_q;
    logic [index_w-1:0] in_index_q;
    logic [data_w-1:0]  in_data_q;
    logic               accept;

    // ------------------------------------------------------------
    // Input stage
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            in_valid_q <= 1'b0;
        end else begin
            in_valid_q <= engine_in_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        in_index_q <= engine_in_index;
        in_data_q  <= engine_in_data;
    end

    // Drop decision on the registered packet
    assign accept = in_valid_q && accept_en;

    // Strobes fire at acceptance so the count closes before the next packet
    assign read_issue  = accept && (opcode == op_read);
    assign write_issue = accept && (opcode == op_write);

    // ------------------------------------------------------------
    // Request and return stage
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            mem_req_valid    <= 1'b0;
            engine_out_valid <= 1'b0;
        end else begin
            mem_req_valid    <= accept;
            engine_out_valid <= rd_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        mem_req_cmd      <= (opcode == op_write) ? cmd_write : cmd_read;
        // base + index * stride
        mem_req_addr     <= base_addr + addr_w'(in_index_q) * stride;
        mem_req_tag      <= in_index_q;
        mem_req_data     <= in_data_q;
        // Tag carries the packet index back
        engine_out_index <= rd_tag;
        engine_out_data  <= rd_data;
    end

endmodule : request_generator

`default_nettype wire

// File: response_router.sv
// Memory response register that splits responses into config and read-data streams
`timescale 1ns/10ps
`default_nettype none

module response_router import rw_engine_pkg::*; (
    input  wire logic               ap_clk,
    input  wire logic               areset_read_write_engine,
    input  wire logic               mem_resp_valid,
    input  wire resp_kind_t         mem_resp_kind,
    input  wire logic [index_w-1:0] mem_resp_tag,
    input  wire logic [data_w-1:0]  mem_resp_data,
    output logic                    cfg_valid,
    output logic [index_w-1:0]      cfg_index,
    output logic [data_w-1:0]       cfg_data,
    output logic                    rd_valid,
    output logic [index_w-1:0]      rd_tag,
    output logic [data_w-1:0]       rd_data
);

    // Payload stage shared by both paths
    logic [index_w-1:0] resp_tag_q;
    logic [data_w-1:0]  resp_data_q;

    // One strobe per destination
    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            cfg_valid <= 1'b0;
            rd_valid  <= 1'b0;
        end else begin
            cfg_valid <= mem_resp_valid && (mem_resp_kind == resp_config);
            rd_valid  <= mem_resp_valid && (mem_resp_kind == resp_data);
        end
    end

    always_ff @(posedge ap_clk) begin
        resp_tag_q  <= mem_resp_tag;
        resp_data_q <= mem_resp_data;
    end

    // Config tag is the word index and data tag the packet index
    assign cfg_index = resp_tag_q;
    assign cfg_data  = resp_data_q;
    assign rd_tag    = resp_tag_q;
    assign rd_data   = resp_data_q;

endmodule : response_router

`default_nettype wire

// File: rw_engine_pkg.sv
// Shared widths, configuration word indices and enum types for the read/write engine
`default_nettype none

package rw_engine_pkg;

    // ------------------------------------------------------------
    // Datapath widths
    // ------------------------------------------------------------
    // Memory byte address
    localparam int addr_w  = 32;
    // Packet payload and memory data
    localparam int data_w  = 32;
    // Packet index, reused as the memory tag
    localparam int index_w = 8;
    // Packet count and internal counters
    localparam int count_w = 16;

    // ------------------------------------------------------------
    // Configuration words
    // ------------------------------------------------------------
    // Number of words loaded from the response stream after reset
    localparam int cfg_words = 4;

    // Word index as carried in the tag of a config response
    localparam logic [index_w-1:0] cfg_base   = index_w'(0);
    localparam logic [index_w-1:0] cfg_stride = index_w'(1);
    localparam logic [index_w-1:0] cfg_count  = index_w'(2);
    localparam logic [index_w-1:0] cfg_opcode = index_w'(3);

    // ------------------------------------------------------------
    // Enumerated types
    // ------------------------------------------------------------
    // Top level sequencing
    typedef enum logic [1:0] {
        st_idle,
        st_configure,
        st_run,
        st_done
    } engine_state_t;

    // Engine operation, taken from the opcode word
    typedef enum logic {
        op_read,
        op_write
    } engine_op_t;

    // Command on the memory request stream
    typedef enum logic {
        cmd_read,
        cmd_write
    } mem_cmd_t;

    // Kind of an incoming memory response
    typedef enum logic {
        resp_config,
        resp_data
    } resp_kind_t;

endpackage : rw_engine_pkg

`default_nettype wire

// File: tb_engine_read_write.sv
// Testbench for the read/write engine with test table, memory model, compare tasks and watchdog
`timescale 1ns/10ps
`default_nettype none

module tb_engine_read_write import rw_engine_pkg::*; ();

    // ------------------------------------------------------------
    // Test table and model constants
    // ------------------------------------------------------------
    typedef struct packed {
        engine_op_t         op;
        logic [addr_w-1:0]  base;
        logic [addr_w-1:0]  stride;
        logic [count_w-1:0] count;
        logic [7:0]         extras;
    } test_row_t;

    typedef struct packed {
        mem_cmd_t           cmd;
        logic [addr_w-1:0]  addr;
        logic [index_w-1:0] tag;
        logic [data_w-1:0]  data;
        logic [31:0]        due;
    } exp_req_t;

    typedef struct packed {
        logic [index_w-1:0] index;
        logic [data_w-1:0]  data;
        logic [31:0]        due;
    } exp_out_t;

    localparam int num_tests = 4;
    localparam int early_packets = 2;
    // Edges from a drive until the monitor sees the 2-cycle result
    localparam int sample_lag = 3;
    localparam logic [data_w-1:0] rd_pattern = 32'hA5C3_5A3C;

    // Opcode, base, stride, count, extra packets past the count
    test_row_t test_tbl [num_tests] = '{
        '{op_write, 32'h0000_1000, 32'h0000_0004, 16'd6, 8'd2},
        '{op_read,  32'h2000_0000, 32'h0000_0008, 16'd5, 8'd3},
        '{op_write, 32'h0000_0040, 32'h0000_0100, 16'd0, 8'd2},
        '{op_read,  32'hFFFF_FF00, 32'h0000_0010, 16'd8, 8'd1}
    };

    // ------------------------------------------------------------
    // DUT signals
    // ------------------------------------------------------------
    logic               ap_clk = 1'b0;
    logic               areset_read_write_engine;
    logic               engine_in_valid;
    logic [index_w-1:0] engine_in_index;
    logic [data_w-1:0]  engine_in_data;
    logic               mem_resp_valid;
    resp_kind_t         mem_resp_kind;
    logic [index_w-1:0] mem_resp_tag;
    logic [data_w-1:0]  mem_resp_data;
    logic               mem_req_valid;
    mem_cmd_t           mem_req_cmd;
    logic [addr_w-1:0]  mem_req_addr;
    logic [index_w-1:0] mem_req_tag;
    logic [data_w-1:0]  mem_req_data;
    logic               engine_out_valid;
    logic [index_w-1:0] engine_out_index;
    logic [data_w-1:0]  engine_out_data;
    logic               done_out;

    // Testbench state
    integer             seed = 80907;
    logic [31:0]        cycle_cnt = '0;
    int                 error_cnt = 0;
    int                 check_cnt = 0;
    int                 req_seen;
    int                 out_seen;
    logic               done_seen;
    exp_req_t           exp_req_q [$];
    exp_out_t           exp_out_q [$];
    logic [addr_w-1:0]  wr_log [$];
    // Config word source for the response driver
    logic               cfg_v;
    logic [index_w-1:0] cfg_tag;
    logic [data_w-1:0]  cfg_word;
    // Read return delay line
    logic [1:0]         rd_pipe_v;
    logic [addr_w-1:0]  rd_pipe_addr [2];
    logic [index_w-1:0] rd_pipe_tag [2];

    engine_read_write dut0 (
        .ap_clk, .areset_read_write_engine,
        .engine_in_valid, .engine_in_index, .engine_in_data,
        .mem_resp_valid, .mem_resp_kind, .mem_resp_tag, .mem_resp_data,
        .mem_req_valid, .mem_req_cmd, .mem_req_addr, .mem_req_tag, .mem_req_data,
        .engine_out_valid, .engine_out_index, .engine_out_data, .done_out
    );

    // 8 ns clock
    always #4 ap_clk = ~ap_clk;

    always @(posedge ap_clk) begin
        cycle_cnt <= cycle_cnt + 32'd1;
    end

    // ------------------------------------------------------------
    // Memory model
    // ------------------------------------------------------------
    // Reads answered 3 cycles after the request and config words in between
    always @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            rd_pipe_v      <= 2'b00;
            mem_resp_valid <= 1'b0;
        end else begin
            rd_pipe_v       <= {rd_pipe_v[0], mem_req_valid && (mem_req_cmd == cmd_read)};
            rd_pipe_addr[0] <= mem_req_addr;
            rd_pipe_addr[1] <= rd_pipe_addr[0];
            rd_pipe_tag[0]  <= mem_req_tag;
            rd_pipe_tag[1]  <= rd_pipe_tag[0];
            if (rd_pipe_v[1]) begin
                mem_resp_valid <= 1'b1;
                mem_resp_kind  <= resp_data;
                mem_resp_tag   <= rd_pipe_tag[1];
                mem_resp_data  <= rd_pipe_addr[1] ^ rd_pattern;
                exp_out_q.push_back('{rd_pipe_tag[1], rd_pipe_addr[1] ^ rd_pattern,
                                      cycle_cnt + sample_lag});
            end else if (cfg_v) begin
                mem_resp_valid <= 1'b1;
                mem_resp_kind  <= resp_config;
                mem_resp_tag   <= cfg_tag;
                mem_resp_data  <= cfg_word;
            end else begin
                mem_resp_valid <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic report_error(input string msg);
        error_cnt++;
        $display("ERROR @%0t: %s", $time, msg);
    endtask

    task automatic compare_request(input exp_req_t exp, input mem_cmd_t cmd,
            input logic [addr_w-1:0] addr, input logic [index_w-1:0] tag,
            input logic [data_w-1:0] data);
        check_cnt++;
        // Request data only matters for writes
        if (cmd !== exp.cmd || addr !== exp.addr || tag !== exp.tag
                || (exp.cmd == cmd_write && data !== exp.data) || cycle_cnt != exp.due) begin
            report_error($sformatf(
                "request %s addr %h tag %h data %h at cycle %0d, expected %s %h %h %h at %0d",
                cmd.name(), addr, tag, data, cycle_cnt,
                exp.cmd.name(), exp.addr, exp.tag, exp.data, exp.due));
        end
    endtask

    task automatic compare_engine_out(input exp_out_t exp, input logic [index_w-1:0] index,
            input logic [data_w-1:0] data);
        check_cnt++;
        if (index !== exp.index || data !== exp.data || cycle_cnt != exp.due) begin
            report_error($sformatf(
                "engine out index %h data %h at cycle %0d, expected %h %h at %0d",
                index, data, cycle_cnt, exp.index, exp.data, exp.due));
        end
    endtask

    task automatic compare_done(input logic exp, input logic act);
        check_cnt++;
        if (act !== exp) begin
            report_error($sformatf("done_out is %b, expected %b", act, exp));
        end
    endtask

    // Reset state of the output strobes
    task automatic expect_quiet();
        check_cnt++;
        if (mem_req_valid !== 1'b0 || engine_out_valid !== 1'b0 || done_out !== 1'b0) begin
            report_error($sformatf("outputs not low around reset, req %b out %b done %b",
                mem_req_valid, engine_out_valid, done_out));
        end
    endtask

    task automatic match_total(input string what, input int exp, input int act);
        check_cnt++;
        if (act != exp) begin
            report_error($sformatf("%s: saw %0d, expected %0d", what, act, exp));
        end
    endtask

    // ------------------------------------------------------------
    // Output monitor
    // ------------------------------------------------------------
    always @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            done_seen = 1'b0;
        end else begin
            if (mem_req_valid) begin
                req_seen++;
                if (mem_req_cmd == cmd_write) begin
                    wr_log.push_back(mem_req_addr);
                end
                if (exp_req_q.size() == 0) begin
                    report_error($sformatf("unexpected request addr %h tag %h",
                        mem_req_addr, mem_req_tag));
                end else begin
                    compare_request(exp_req_q.pop_front(), mem_req_cmd, mem_req_addr,
                        mem_req_tag, mem_req_data);
                end
            end
            if (engine_out_valid) begin
                out_seen++;
                if (exp_out_q.size() == 0) begin
                    report_error($sformatf("unexpected engine out index %h", engine_out_index));
                end else begin
                    compare_engine_out(exp_out_q.pop_front(), engine_out_index, engine_out_data);
                end
            end
            // Done only with nothing left in flight and sticky afterwards
            if (done_out) begin
                if (exp_req_q.size() != 0 || exp_out_q.size() != 0 || rd_pipe_v != 2'b00) begin
                    report_error("done_out high with requests or reads still pending");
                end
                done_seen = 1'b1;
            end else if (done_seen) begin
                report_error("done_out fell before reset");
            end
        end
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    task automatic reset_dut();
        areset_read_write_engine <= 1'b1;
        exp_req_q.delete();
        exp_out_q.delete();
        wr_log.delete();
        req_seen = 0;
        out_seen = 0;
        for (int k = 0; k < 16; k++) begin
            @(posedge ap_clk);
            if (k >= 1) begin
                expect_quiet();
            end
        end
        areset_read_write_engine <= 1'b0;
        @(posedge ap_clk);
        expect_quiet();
    endtask

    task automatic send_packet(input logic [index_w-1:0] idx, input logic [data_w-1:0] dat);
        engine_in_valid <= 1'b1;
        engine_in_index <= idx;
        engine_in_data  <= dat;
        @(posedge ap_clk);
    endtask

    // Base, stride, count, opcode on consecutive cycles
    task automatic send_config(input test_row_t row);
        cfg_v    <= 1'b1;
        cfg_tag  <= cfg_base;
        cfg_word <= row.base;
        @(posedge ap_clk);
        cfg_tag  <= cfg_stride;
        cfg_word <= row.stride;
        @(posedge ap_clk);
        cfg_tag  <= cfg_count;
        cfg_word <= data_w'(row.count);
        @(posedge ap_clk);
        cfg_tag  <= cfg_opcode;
        cfg_word <= data_w'(row.op);
        @(posedge ap_clk);
        cfg_v    <= 1'b0;
    endtask

    task automatic wait_for_done();
        while (done_out !== 1'b1) begin
            @(posedge ap_clk);
        end
    endtask

    task automatic run_test(input int t);
        test_row_t          row;
        exp_req_t           exp;
        logic [index_w-1:0] idx;
        logic [data_w-1:0]  dat;
        int                 errs_before;
        row = test_tbl[t];
        errs_before = error_cnt;
        reset_dut();
        // Engine still configuring so these packets must vanish
        for (int i = 0; i < early_packets; i++) begin
            idx = $random(seed);
            dat = $random(seed);
            send_packet(idx, dat);
        end
        engine_in_valid <= 1'b0;
        send_config(row);
        // Let the FSM reach run
        repeat (4) @(posedge ap_clk);
        for (int i = 0; i < row.count + row.extras; i++) begin
            idx = $random(seed);
            dat = $random(seed);
            if (i < row.count) begin
                exp.cmd  = (row.op == op_write) ? cmd_write : cmd_read;
                exp.addr = row.base + addr_w'(idx) * row.stride;
                exp.tag  = idx;
                exp.data = dat;
                exp.due  = cycle_cnt + sample_lag;
                exp_req_q.push_back(exp);
            end
            send_packet(idx, dat);
        end
        engine_in_valid <= 1'b0;
        wait_for_done();
        // Hold a while so late strobes or a falling done get caught
        repeat (4) @(posedge ap_clk);
        compare_done(1'b1, done_out);
        match_total("memory requests", row.count, req_seen);
        match_total("engine outputs", (row.op == op_read) ? row.count : 0, out_seen);
        match_total("writes recorded", (row.op == op_write) ? row.count : 0, wr_log.size());
        $display("Test %0d: %s base %h stride %h count %0d extras %0d, %0d errors",
            t, row.op.name(), row.base, row.stride, row.count, row.extras,
            error_cnt - errs_before);
    endtask

    // ------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------
    initial begin
        areset_read_write_engine = 1'b1;
        engine_in_valid = 1'b0;
        engine_in_index = '0;
        engine_in_data  = '0;
        mem_resp_valid  = 1'b0;
        mem_resp_kind   = resp_config;
        mem_resp_tag    = '0;
        mem_resp_data   = '0;
        cfg_v    = 1'b0;
        cfg_tag  = '0;
        cfg_word = '0;
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("Tests %0d, checks %0d, errors %0d", num_tests, check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        longint limit_cycles;
        limit_cycles = 0;
        for (int t = 0; t < num_tests; t++) begin
            limit_cycles += test_tbl[t].count + test_tbl[t].extras + 40;
        end
        #(limit_cycles * 8 * 4);
        $display("Timeout: the tests did not complete in %0d cycles", limit_cycles * 4);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule : tb_engine_read_write

`default_nettype wire
